// File: alu_core.sv
`timescale 1ns/1ns

module alu_core
    import isa_pkg::*;
(
    input  alu_op_e op,
    input  word_t   rs_value,
    input  word_t   rt_value,
    input  imm16_t  imm,
    input  logic    use_imm,
    input  shamt_t  shamt,
    input  word_t   pc,
    output word_t   value,
    output logic    overflow
);

    word_t imm_ext;
    word_t operand_b;
    word_t sum;
    word_t diff;
    word_t addr;

    assign imm_ext   = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign operand_b = use_imm ? imm_ext : rt_value;
    assign sum       = rs_value + operand_b;
    assign diff      = rs_value - operand_b;
    assign addr      = rs_value + imm_ext; // loads and stores always use the offset.

    always_comb begin
        value    = pc; // eret and nop just carry the pc along.
        overflow = 1'b0;
        case (op)
            OP_ADD: begin
                value    = sum;
                overflow = (rs_value[WORD_W-1] == operand_b[WORD_W-1]) &&
                           (sum[WORD_W-1] != rs_value[WORD_W-1]);
            end
            OP_ADDU: value = sum;
            OP_SUB: begin
                value    = diff;
                overflow = (rs_value[WORD_W-1] != operand_b[WORD_W-1]) &&
                           (diff[WORD_W-1] != rs_value[WORD_W-1]);
            end
            OP_SUBU: value = diff;
            OP_AND:  value = rs_value & operand_b;
            OP_OR:   value = rs_value | operand_b;
            OP_XOR:  value = rs_value ^ operand_b;
            OP_NOR:  value = ~(rs_value | operand_b);
            OP_SLT:  value = {{(WORD_W-1){1'b0}}, $signed(rs_value) < $signed(operand_b)};
            OP_SLTU: value = {{(WORD_W-1){1'b0}}, rs_value < operand_b};
            OP_SLL:  value = rt_value << shamt;
            OP_SRL:  value = rt_value >> shamt;
            OP_SRA:  value = $signed(rt_value) >>> shamt;
            OP_LUI:  value = {imm, {(WORD_W-IMM_W){1'b0}}};
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL: begin
                value = addr;
            end
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC: begin
                value = addr;
            end
            default: ;
        endcase
    end

endmodule

// File: bit_count_unit.sv
`timescale 1ns/1ns

module bit_count_unit
    import isa_pkg::*;
(
    input  logic   Clk,
    input  logic   reset,
    input  logic   flush,
    input  logic   start,
    input  logic   count_ones,
    input  word_t  operand,
    output logic   done,
    output count_t count
);

    word_t shift_reg;
    logic  want_bit;
    logic  running;
    logic  msb_match;
    logic  finish;

    assign msb_match = shift_reg[WORD_W-1] == want_bit;
    // stop on the first differing bit, or once all 32 bits matched.
    assign finish    = running && (!msb_match || count == count_t'(WORD_W - 1));

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
            end else if (finish) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            shift_reg <= operand;
            want_bit  <= count_ones;
            count     <= '0;
        end else if (running && msb_match) begin
            shift_reg <= shift_reg << 1;
            count     <= count + 1'b1;
        end
    end

    a_start_when_idle: assert property (@(posedge Clk) disable iff (reset)
        start |-> !running)
        else $error("count started while a count is still running");

endmodule

// File: build.f
isa_pkg.sv
pipe_pkg.sv
operand_bypass.sv
alu_core.sv
mem_access_unit.sv
bit_count_unit.sv
execute_result_reg.sv
execute_stage.sv
tb_execute_stage.sv

// File: execute_result_reg.sv
`timescale 1ns/1ns

module execute_result_reg
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      Clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      issue_valid,
    input  issue_t    issue,
    input  word_t     value,
    input  logic      overflow,
    input  mem_ctrl_t mem,
    input  logic      llbit,
    input  logic      count_done,
    input  count_t    count,
    output logic      count_start,
    output logic      out_valid,
    output result_t   result,
    output logic      busy
);

    stage_state_e state;
    logic         is_count;
    word_t        park_pc;
    reg_id_t      park_dest_id;
    logic         park_reg_write;
    result_t      direct;
    result_t      counted;

    assign is_count    = issue.op inside {OP_CLO, OP_CLZ};
    assign count_start = issue_valid && is_count;
    assign busy        = state == COUNTING;

    always_comb begin
        direct            = '0;
        direct.pc         = issue.pc;
        direct.dest_id    = issue.dest_id;
        direct.reg_write  = issue.reg_write;
        direct.data       = (issue.op == OP_SC) ? {{(WORD_W-1){1'b0}}, llbit} : value;
        direct.store_data = issue.rt_data; // already forwarded.
        direct.overflow   = overflow;
        direct.mem        = mem;
    end

    always_comb begin
        counted           = '0;
        counted.pc        = park_pc;
        counted.dest_id   = park_dest_id;
        counted.reg_write = park_reg_write;
        counted.data      = {{(WORD_W-COUNT_W){1'b0}}, count};
    end

    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            state     <= IDLE;
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= 1'b0;
            result    <= '0; // idle cycles carry no write.
            case (state)
                IDLE: begin
                    if (count_start) begin
                        state <= COUNTING;
                    end else if (issue_valid) begin
                        out_valid <= 1'b1;
                        result    <= direct;
                    end
                end
                COUNTING: begin
                    if (count_done) begin
                        state     <= IDLE;
                        out_valid <= 1'b1;
                        result    <= counted;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // fields of the parked clo/clz.
    always_ff @(posedge Clk) begin
        if (count_start) begin
            park_pc        <= issue.pc;
            park_dest_id   <= issue.dest_id;
            park_reg_write <= issue.reg_write;
        end
    end

    a_no_issue_when_busy: assert property (@(posedge Clk) disable iff (reset)
        busy |-> !issue_valid)
        else $error("instruction issued while the execute stage is busy");

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    Clk,
    input  logic    reset,
    input  logic    flush,
    input  logic    issue_valid,
    input  issue_t  issue,
    input  fwd_t    mem_fwd,
    output logic    out_valid,
    output result_t result,
    output logic    busy
);

    word_t     rs_value;
    word_t     rt_value;
    word_t     alu_value;
    logic      alu_overflow;
    mem_ctrl_t mem_ctrl;
    logic      llbit;
    logic      count_start;
    logic      count_done;
    count_t    count;
    fwd_t      stage_fwd;
    issue_t    issue_fwd;

    // a load result here is only its address, so it is not forwarded.
    assign stage_fwd = '{valid:   out_valid && result.reg_write && !result.mem.mem_read,
                         dest_id: result.dest_id,
                         data:    result.data};

    always_comb begin
        issue_fwd         = issue;
        issue_fwd.rs_data = rs_value;
        issue_fwd.rt_data = rt_value;
    end

    operand_bypass operand_bypass_i (
        .issue     (issue),
        .stage_fwd (stage_fwd),
        .mem_fwd   (mem_fwd),
        .rs_value  (rs_value),
        .rt_value  (rt_value)
    );

    alu_core alu_core_i (
        .op       (issue.op),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .imm      (issue.imm),
        .use_imm  (issue.use_imm),
        .shamt    (issue.shamt),
        .pc       (issue.pc),
        .value    (alu_value),
        .overflow (alu_overflow)
    );

    mem_access_unit mem_access_unit_i (
        .Clk         (Clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .op          (issue.op),
        .addr        (alu_value),
        .mem         (mem_ctrl),
        .llbit       (llbit)
    );

    bit_count_unit bit_count_unit_i (
        .Clk        (Clk),
        .reset      (reset),
        .flush      (flush),
        .start      (count_start),
        .count_ones (issue.op == OP_CLO),
        .operand    (rs_value),
        .done       (count_done),
        .count      (count)
    );

    execute_result_reg execute_result_reg_i (
        .Clk         (Clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue_fwd),
        .value       (alu_value),
        .overflow    (alu_overflow),
        .mem         (mem_ctrl),
        .llbit       (llbit),
        .count_done  (count_done),
        .count       (count),
        .count_start (count_start),
        .out_valid   (out_valid),
        .result      (result),
        .busy        (busy)
    );

endmodule

// File: isa_pkg.sv
package isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_ID_W  = 5;
    localparam int IMM_W     = 16;
    localparam int SHAMT_W   = 5;
    localparam int BYTE_EN_W = 4;
    localparam int COUNT_W   = 6;
    localparam int OP_W      = 6;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_ID_W-1:0]  reg_id_t;
    typedef logic [IMM_W-1:0]     imm16_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [BYTE_EN_W-1:0] byte_en_t;

    // leading-bit count, 0 to 32.
    typedef logic [COUNT_W-1:0]   count_t;

    localparam reg_id_t ZERO_REG = '0;

    // nop first, so an all-zero issue record does nothing.
    typedef enum logic [OP_W-1:0] {
        OP_NOP,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC,
        OP_CLO, OP_CLZ,
        OP_ERET
    } alu_op_e;

endpackage

// File: mem_access_unit.sv
`timescale 1ns/1ns

module mem_access_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      Clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      issue_valid,
    input  alu_op_e   op,
    input  word_t     addr,
    output mem_ctrl_t mem,
    output logic      llbit
);

    logic [1:0] offset;
    logic       is_load;
    logic       is_store;
    logic       align_err;
    byte_en_t   store_en;

    assign offset   = addr[1:0];
    assign is_load  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC};

    always_comb begin
        case (op)
            OP_LW, OP_LL, OP_SW, OP_SC: align_err = offset != 2'b00;
            OP_LH, OP_LHU, OP_SH:       align_err = offset[0];
            default:                    align_err = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_SW, OP_SC: store_en = 4'b1111;
            OP_SH:        store_en = 4'b0011 << offset;
            OP_SB:        store_en = 4'b0001 << offset;
            OP_SWL:       store_en = 4'b1111 >> (2'd3 - offset);
            OP_SWR:       store_en = 4'b1111 << offset;
            default:      store_en = '0;
        endcase
    end

    always_comb begin
        mem            = '0;
        mem.mem_read   = is_load;
        mem.mem_access = is_load | is_store;
        mem.unaligned  = align_err;
        // a failed sc must not touch memory.
        mem.byte_en    = (align_err || (op == OP_SC && !llbit)) ? '0 : store_en;
        mem.load_kind  = {op == OP_LB, op == OP_LBU, op == OP_LH, op == OP_LHU,
                          op == OP_LW || op == OP_LL, op == OP_LWL, op == OP_LWR,
                          op == OP_SWL, op == OP_SWR};
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            llbit <= 1'b0;
        end else if (issue_valid && !flush) begin
            if (op == OP_LL) begin
                llbit <= 1'b1;
            end else if (op == OP_SC || op == OP_ERET) begin
                llbit <= 1'b0;
            end
        end
    end

    a_store_only_enables: assert property (@(posedge Clk) disable iff (reset)
        !is_store |-> mem.byte_en == '0)
        else $error("byte enables set for a non-store op %s", op.name());

endmodule

// File: operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  issue_t issue,
    input  fwd_t   stage_fwd,
    input  fwd_t   mem_fwd,
    output word_t  rs_value,
    output word_t  rt_value
);

    // the younger write wins over the older one.
    function automatic word_t pick_operand(
        input reg_id_t id,
        input word_t   rf_value,
        input fwd_t    near,
        input fwd_t    far
    );
        word_t picked;
        picked = rf_value;
        if (id != ZERO_REG) begin
            if (near.valid && near.dest_id == id) begin
                picked = near.data;
            end else if (far.valid && far.dest_id == id) begin
                picked = far.data;
            end
        end
        return picked;
    endfunction

    assign rs_value = pick_operand(issue.rs_id, issue.rs_data, stage_fwd, mem_fwd);
    assign rt_value = pick_operand(issue.rt_id, issue.rt_data, stage_fwd, mem_fwd);

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    localparam int LOAD_KIND_W = 9;

    // one-hot of {lb, lbu, lh, lhu, lw/ll, lwl, lwr, swl, swr}.
    typedef logic [LOAD_KIND_W-1:0] load_kind_t;

    typedef struct packed {
        word_t   pc;
        alu_op_e op;
        logic    use_imm;
        imm16_t  imm;
        shamt_t  shamt;
        reg_id_t rs_id;
        reg_id_t rt_id;
        word_t   rs_data;
        word_t   rt_data;
        reg_id_t dest_id;
        logic    reg_write;
    } issue_t;

    // a pending register write seen by the bypass.
    typedef struct packed {
        logic    valid;
        reg_id_t dest_id;
        word_t   data;
    } fwd_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_access;
        byte_en_t   byte_en;
        logic       unaligned;
        load_kind_t load_kind;
    } mem_ctrl_t;

    typedef struct packed {
        word_t     pc;
        reg_id_t   dest_id;
        logic      reg_write;
        word_t     data;       // alu value, address, sc status or count.
        word_t     store_data;
        logic      overflow;
        mem_ctrl_t mem;
    } result_t;

    typedef enum logic {
        IDLE,
        COUNTING
    } stage_state_e;

endpackage

// File: tb_execute_stage.sv
`timescale 1ns/1ns

module tb_execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
();

    logic    Clk;
    logic    reset;
    logic    flush;
    logic    issue_valid;
    issue_t  issue;
    fwd_t    mem_fwd;
    logic    out_valid;
    result_t result;
    logic    busy;

    word_t   rng_state;
    word_t   pc_next;
    logic    ll_model; // expected load-linked bit.

    execute_stage execute_stage_i (
        .Clk         (Clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .mem_fwd     (mem_fwd),
        .out_valid   (out_valid),
        .result      (result),
        .busy        (busy)
    );

    always #10 Clk = ~Clk;

    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic issue_t make_issue(
        input alu_op_e op,
        input reg_id_t rs_id,
        input word_t   rs_data,
        input reg_id_t rt_id,
        input word_t   rt_data,
        input logic    use_imm,
        input imm16_t  imm,
        input reg_id_t dest_id
    );
        issue_t ins;
        ins           = '0;
        ins.pc        = pc_next;
        ins.op        = op;
        ins.use_imm   = use_imm;
        ins.imm       = imm;
        ins.shamt     = imm[10:6]; // same field as the instruction word.
        ins.rs_id     = rs_id;
        ins.rt_id     = rt_id;
        ins.rs_data   = rs_data;
        ins.rt_data   = rt_data;
        ins.dest_id   = dest_id;
        ins.reg_write = !(op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR});
        pc_next       = pc_next + 4;
        return ins;
    endfunction

    function automatic word_t model_value(input issue_t ins, input word_t rs, input word_t rt);
        word_t se;
        word_t b;
        se = {{16{ins.imm[15]}}, ins.imm};
        b  = ins.use_imm ? se : rt;
        case (ins.op)
            OP_ADD, OP_ADDU: return rs + b;
            OP_SUB, OP_SUBU: return rs - b;
            OP_AND:  return rs & b;
            OP_OR:   return rs | b;
            OP_XOR:  return rs ^ b;
            OP_NOR:  return ~(rs | b);
            OP_SLT:  return word_t'($signed(rs) < $signed(b));
            OP_SLTU: return word_t'(rs < b);
            OP_SLL:  return rt << ins.shamt;
            OP_SRL:  return rt >> ins.shamt;
            OP_SRA:  return word_t'($signed(rt) >>> ins.shamt);
            OP_LUI:  return {ins.imm, 16'h0000};
            default: return rs + se; // load and store address.
        endcase
    endfunction

    // exact sum in 64 bits, overflow when it leaves the 32-bit signed range.
    function automatic logic model_overflow(input issue_t ins, input word_t rs, input word_t rt);
        word_t  bw;
        longint s;
        bw = ins.use_imm ? {{16{ins.imm[15]}}, ins.imm} : rt;
        case (ins.op)
            OP_ADD:  s = longint'($signed(rs)) + longint'($signed(bw));
            OP_SUB:  s = longint'($signed(rs)) - longint'($signed(bw));
            default: s = 0;
        endcase
        return s[32] != s[31];
    endfunction

    function automatic logic model_unaligned(input alu_op_e op, input logic [1:0] off);
        case (op)
            OP_LW, OP_LL, OP_SW, OP_SC: return off != 2'd0;
            OP_LH, OP_LHU, OP_SH:       return off[0];
            default:                    return 1'b0;
        endcase
    endfunction

    function automatic byte_en_t model_byte_en(input alu_op_e op, input logic [1:0] off,
                                               input logic ll);
        byte_en_t en;
        case (op)
            OP_SW, OP_SC: en = 4'b1111;
            OP_SH:   en = byte_en_t'(4'b0011 << off);
            OP_SB:   en = byte_en_t'(4'b0001 << off);
            OP_SWL:  en = byte_en_t'(4'b1111 >> (2'd3 - off));
            OP_SWR:  en = byte_en_t'(4'b1111 << off);
            default: en = 4'b0000;
        endcase
        if (model_unaligned(op, off) || (op == OP_SC && !ll)) begin
            en = 4'b0000;
        end
        return en;
    endfunction

    // msb to lsb: lb, lbu, lh, lhu, lw/ll, lwl, lwr, swl, swr.
    function automatic load_kind_t model_load_kind(input alu_op_e op);
        case (op)
            OP_LB:        return 9'b1_0000_0000;
            OP_LBU:       return 9'b0_1000_0000;
            OP_LH:        return 9'b0_0100_0000;
            OP_LHU:       return 9'b0_0010_0000;
            OP_LW, OP_LL: return 9'b0_0001_0000;
            OP_LWL:       return 9'b0_0000_1000;
            OP_LWR:       return 9'b0_0000_0100;
            OP_SWL:       return 9'b0_0000_0010;
            OP_SWR:       return 9'b0_0000_0001;
            default:      return 9'b0_0000_0000;
        endcase
    endfunction

    function automatic count_t leading_count(input word_t v, input logic ones);
        count_t n;
        n = 0;
        for (int i = WORD_W - 1; i >= 0 && v[i] == ones; i--) begin
            n++;
        end
        return n;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_reg_id(input string name, input reg_id_t got, input reg_id_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_load_kind(input string name, input load_kind_t got,
                                   input load_kind_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    // strobe one instruction, return at the falling edge of the next cycle.
    task automatic send(input issue_t ins);
        @(negedge Clk);
        issue       = ins;
        issue_valid = 1'b1;
        @(negedge Clk);
        issue_valid = 1'b0;
        issue       = '0;
        case (ins.op)
            OP_LL:          ll_model = 1'b1;
            OP_SC, OP_ERET: ll_model = 1'b0;
            default: ;
        endcase
    endtask

    task automatic wait_out_valid(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (out_valid !== 1'b1) begin
            if (cycles == limit) begin
                stop_with_error({"timeout: out_valid never came for ", what});
            end
            @(negedge Clk);
            cycles++;
        end
    endtask

    task automatic check_plain(input issue_t ins, input word_t rs, input word_t rt);
        check_flag("out_valid", out_valid, 1'b1);
        check_word("result.data", result.data, model_value(ins, rs, rt));
        check_flag("result.overflow", result.overflow, model_overflow(ins, rs, rt));
        check_flag("result.reg_write", result.reg_write, ins.reg_write);
        check_reg_id("result.dest_id", result.dest_id, ins.dest_id);
        check_word("result.pc", result.pc, ins.pc);
        check_byte_en("result.mem.byte_en", result.mem.byte_en, 4'b0000);
    endtask

    task automatic run_alu(input issue_t ins);
        send(ins);
        check_plain(ins, ins.rs_data, ins.rt_data);
    endtask

    // second issues while the first is in the result register.
    task automatic run_pair(input issue_t first, input issue_t second,
                            input word_t second_rs, input word_t second_rt);
        @(negedge Clk);
        issue       = first;
        issue_valid = 1'b1;
        @(negedge Clk);
        check_plain(first, first.rs_data, first.rt_data);
        issue = second;
        @(negedge Clk);
        issue_valid = 1'b0;
        issue       = '0;
        check_plain(second, second_rs, second_rt);
    endtask

    task automatic run_mem(input issue_t ins);
        word_t      addr;
        logic [1:0] off;
        word_t      exp_data;
        byte_en_t   exp_en;
        addr     = ins.rs_data + {{16{ins.imm[15]}}, ins.imm};
        off      = addr[1:0];
        exp_data = (ins.op == OP_SC) ? word_t'(ll_model) : addr;
        exp_en   = model_byte_en(ins.op, off, ll_model);
        send(ins);
        check_flag("out_valid", out_valid, 1'b1);
        check_word("result.data", result.data, exp_data);
        check_byte_en("result.mem.byte_en", result.mem.byte_en, exp_en);
        check_flag("result.mem.mem_read", result.mem.mem_read,
                   ins.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL});
        check_flag("result.mem.mem_access", result.mem.mem_access,
                   ins.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR, OP_LL,
                                  OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_SC});
        check_flag("result.mem.unaligned", result.mem.unaligned, model_unaligned(ins.op, off));
        check_load_kind("result.mem.load_kind", result.mem.load_kind, model_load_kind(ins.op));
        check_word("result.store_data", result.store_data, ins.rt_data);
        check_flag("result.reg_write", result.reg_write, ins.reg_write);
        check_reg_id("result.dest_id", result.dest_id, ins.dest_id);
    endtask

    task automatic run_count(input alu_op_e op, input word_t value);
        issue_t ins;
        count_t exp;
        ins = make_issue(op, 5'd4, value, 5'd0, 32'h0, 1'b0, 16'h0, 5'd9);
        exp = leading_count(value, op == OP_CLO);
        send(ins);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("busy", busy, 1'b1);
        wait_out_valid(40, op.name());
        check_flag("busy", busy, 1'b0);
        check_count("result.data count", count_t'(result.data), exp);
        check_word("result.data", result.data, word_t'(exp));
        check_word("result.pc", result.pc, ins.pc);
        check_flag("result.reg_write", result.reg_write, 1'b1);
        check_reg_id("result.dest_id", result.dest_id, ins.dest_id);
    endtask

    task automatic test_alu_ops();
        issue_t ins;
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = OP_ADD; k <= OP_LUI; k++) begin
                ins = make_issue(alu_op_e'(k), 5'd1, next_rand(), 5'd2, next_rand(),
                                 rep[0], imm16_t'(next_rand()), 5'd3);
                run_alu(ins);
            end
        end
        run_alu(make_issue(OP_ADD, 5'd1, 32'h7fff_ffff, 5'd2, 32'h1, 1'b0, 16'h0, 5'd3));
        run_alu(make_issue(OP_ADD, 5'd1, 32'h8000_0000, 5'd2, 32'hffff_ffff, 1'b0, 16'h0, 5'd3));
        run_alu(make_issue(OP_ADD, 5'd1, 32'h7fff_fff0, 5'd2, 32'h0, 1'b1, 16'h0010, 5'd3));
        run_alu(make_issue(OP_ADDU, 5'd1, 32'h7fff_ffff, 5'd2, 32'h1, 1'b0, 16'h0, 5'd3));
        run_alu(make_issue(OP_SUB, 5'd1, 32'h8000_0000, 5'd2, 32'h1, 1'b0, 16'h0, 5'd3));
        run_alu(make_issue(OP_SUB, 5'd1, 32'h7fff_ffff, 5'd2, 32'hffff_ffff, 1'b0, 16'h0, 5'd3));
        run_alu(make_issue(OP_SUB, 5'd1, 32'h5, 5'd2, 32'h3, 1'b0, 16'h0, 5'd3));
    endtask

    task automatic test_forwarding();
        issue_t first;
        issue_t second;
        first  = make_issue(OP_ADDU, 5'd1, next_rand(), 5'd2, next_rand(), 1'b0, 16'h0, 5'd5);
        second = make_issue(OP_SUBU, 5'd5, 32'hdead_beef, 5'd2, next_rand(), 1'b0, 16'h0, 5'd6);
        run_pair(first, second, first.rs_data + first.rt_data, second.rt_data);
        first  = make_issue(OP_ADDU, 5'd1, next_rand(), 5'd2, next_rand(), 1'b0, 16'h0, 5'd5);
        second = make_issue(OP_XOR, 5'd2, next_rand(), 5'd5, 32'hdead_beef, 1'b0, 16'h0, 5'd7);
        run_pair(first, second, second.rs_data, first.rs_data + first.rt_data);
        mem_fwd = '{valid: 1'b1, dest_id: 5'd9, data: 32'h1234_5678};
        second  = make_issue(OP_OR, 5'd9, 32'hdead_beef, 5'd2, 32'h0, 1'b0, 16'h0, 5'd10);
        send(second);
        check_plain(second, 32'h1234_5678, 32'h0);
        // this stage is younger than the memory stage.
        mem_fwd = '{valid: 1'b1, dest_id: 5'd5, data: 32'h0bad_0bad};
        first   = make_issue(OP_ADDU, 5'd1, next_rand(), 5'd2, next_rand(), 1'b0, 16'h0, 5'd5);
        second  = make_issue(OP_ADDU, 5'd5, 32'hdead_beef, 5'd2, next_rand(), 1'b0, 16'h0, 5'd6);
        run_pair(first, second, first.rs_data + first.rt_data, second.rt_data);
        mem_fwd = '{valid: 1'b1, dest_id: ZERO_REG, data: 32'h0bad_0bad};
        first   = make_issue(OP_ADDU, 5'd1, next_rand(), 5'd2, next_rand(), 1'b0, 16'h0, ZERO_REG);
        second  = make_issue(OP_ADDU, ZERO_REG, 32'h0, 5'd2, next_rand(), 1'b0, 16'h0, 5'd6);
        run_pair(first, second, 32'h0, second.rt_data);
        mem_fwd = '0;
    endtask

    task automatic test_mem_access();
        issue_t ins;
        imm16_t imm;
        for (int k = OP_LB; k <= OP_SC; k++) begin
            for (int off = 0; off < 4; off++) begin
                imm      = imm16_t'(next_rand());
                imm[1:0] = 2'(off);
                ins = make_issue(alu_op_e'(k), 5'd1, next_rand() & 32'hffff_fffc, 5'd2,
                                 next_rand(), 1'b1, imm, 5'd3);
                run_mem(ins);
            end
        end
    endtask

    task automatic test_ll_sc();
        issue_t sc_ins;
        issue_t ll_ins;
        issue_t eret_ins;
        sc_ins   = make_issue(OP_SC, 5'd1, 32'h0000_1000, 5'd2, 32'h55aa_55aa, 1'b1, 16'h0010, 5'd2);
        ll_ins   = make_issue(OP_LL, 5'd1, 32'h0000_1000, 5'd0, 32'h0, 1'b1, 16'h0010, 5'd2);
        eret_ins = make_issue(OP_ERET, 5'd0, 32'h0, 5'd0, 32'h0, 1'b0, 16'h0, 5'd0);
        run_mem(sc_ins); // llbit is clear out of reset.
        check_word("sc status", result.data, 32'd0);
        check_byte_en("sc byte_en", result.mem.byte_en, 4'b0000);
        run_mem(ll_ins);
        run_mem(sc_ins);
        check_word("sc status", result.data, 32'd1);
        check_byte_en("sc byte_en", result.mem.byte_en, 4'b1111);
        @(negedge Clk); // the cycle after a store carries no write.
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("result.reg_write", result.reg_write, 1'b0);
        check_byte_en("result.mem.byte_en", result.mem.byte_en, 4'b0000);
        run_mem(ll_ins);
        send(eret_ins);
        run_mem(sc_ins);
        check_word("sc status", result.data, 32'd0);
        check_byte_en("sc byte_en", result.mem.byte_en, 4'b0000);
    endtask

    task automatic test_bit_count();
        word_t values[8];
        values[0] = 32'h0000_0000;
        values[1] = 32'hffff_ffff;
        values[2] = 32'h1 << (next_rand() % 32);
        values[3] = ~values[2];
        values[4] = next_rand();
        values[5] = next_rand() | 32'hf000_0000;
        values[6] = next_rand() >> 9;
        values[7] = next_rand();
        for (int i = 0; i < 8; i++) begin
            run_count(OP_CLO, values[i]);
            run_count(OP_CLZ, values[i]);
        end
    endtask

    task automatic test_flush();
        issue_t ins;
        ins = make_issue(OP_CLZ, 5'd4, 32'h0, 5'd0, 32'h0, 1'b0, 16'h0, 5'd9);
        send(ins);
        repeat (5) @(negedge Clk);
        check_flag("busy", busy, 1'b1);
        flush = 1'b1;
        @(negedge Clk);
        flush = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        repeat (40) begin
            @(negedge Clk);
            check_flag("out_valid", out_valid, 1'b0); // the aborted count stays dead.
        end
        run_alu(make_issue(OP_ADDU, 5'd1, next_rand(), 5'd2, next_rand(), 1'b0, 16'h0, 5'd3));
    endtask

    initial begin
        Clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        mem_fwd     = '0;
        rng_state   = 32'd51441;
        pc_next     = 32'h0040_0000;
        ll_model    = 1'b0;
        repeat (16) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("result.reg_write", result.reg_write, 1'b0);
        check_byte_en("result.mem.byte_en", result.mem.byte_en, 4'b0000);
        test_ll_sc();
        test_alu_ops();
        test_forwarding();
        test_mem_access();
        test_bit_count();
        test_flush();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
